// ==== design/qspi_pkg.sv ====
package qspi_pkg;

	////////////////////////////////////////
	// widths with a meaning

	typedef logic [7:0] byte_t;      // one data byte on the write or read path
	typedef logic [3:0] nibble_t;    // one x4 transfer on DQ
	typedef logic [31:0] word_t;     // register value
	typedef logic [7:0] insn_t;      // instruction byte
	typedef logic [2:0] reg_addr_t;  // register index, 8 registers max

	localparam int BYTES_PER_WORD = 4;  // words go out msb first

	////////////////////////////////////////
	// instruction layout

	// bit 7 selects read, 6:3 must be zero, 2:0 is the start register
	localparam int INSN_READ_BIT = 7;
	localparam int INSN_RSVD_MSB = 6;
	localparam int INSN_RSVD_LSB = 3;
	localparam int INSN_ADDR_MSB = 2;

	////////////////////////////////////////
	// command from decode to execute and result

	typedef struct packed {
		logic is_read;    // data flows from device to host
		logic legal;      // reserved bits were clear
		reg_addr_t addr;  // first register of the burst
	} qspi_cmd_t;

	////////////////////////////////////////
	// transceiver states

	typedef enum logic [2:0] {
		st_deselected = 3'd0,  // cs# high, waiting for start
		st_insn       = 3'd1,  // shifting in the two instruction nibbles
		st_turnaround = 3'd2,  // one dummy sck, bus changes direction here
		st_wr_hi      = 3'd3,  // next rise carries the high nibble of a write byte
		st_wr_lo      = 3'd4,  // next rise carries the low nibble
		st_rd_hi      = 3'd5,  // next rise drives the high nibble of a read byte
		st_rd_lo      = 3'd6   // next rise drives the low nibble
	} xcvr_state_t;

endpackage

// ==== design/qspi_input_sync.sv ====
`timescale 1ns/1ps

module qspi_input_sync (
	input logic clk,
	input logic rst_n,
	input logic sck,
	input logic cs_n,
	input qspi_pkg::nibble_t dq_in,
	output logic cs_n_s,               // synchronized cs#
	output qspi_pkg::nibble_t dq_s,    // synchronized dq
	output logic sck_rise,             // one clk per sck rising edge
	output logic start                 // one clk per cs# falling edge
);

	logic [2:0] sck_ff;             // sck chain, stage 2 is the safe copy
	logic [2:0] cs_ff;              // cs# chain, idles high
	qspi_pkg::nibble_t dq_ff [3];   // dq chain, all four lanes together
	logic sck_prev;                 // last synchronized sck
	logic cs_prev;                  // last synchronized cs#

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sck_ff <= '0;
			cs_ff <= '1;  // deselected out of reset
			dq_ff[0] <= '0;
			dq_ff[1] <= '0;
			dq_ff[2] <= '0;
			sck_prev <= 1'b0;
			cs_prev <= 1'b1;
			sck_rise <= 1'b0;
			start <= 1'b0;
		end else begin
			sck_ff <= {sck_ff[1:0], sck};
			cs_ff <= {cs_ff[1:0], cs_n};
			dq_ff[0] <= dq_in;
			dq_ff[1] <= dq_ff[0];
			dq_ff[2] <= dq_ff[1];
			sck_prev <= sck_ff[2];
			cs_prev <= cs_ff[2];
			sck_rise <= sck_ff[2] & ~sck_prev;  // low then high
			start <= cs_prev & ~cs_ff[2];       // high then low
		end
	end

	assign cs_n_s = cs_ff[2];
	assign dq_s = dq_ff[2];

endmodule

// ==== design/qspi_device_if.sv ====
`timescale 1ns/1ps

module qspi_device_if (
	input logic clk,
	input logic rst_n,
	input logic cs_n_s,
	input qspi_pkg::nibble_t dq_s,
	input logic sck_rise,
	input logic start,
	input logic rd_mode,               // from decode, valid from insn_valid on
	input logic rd_valid,              // read byte strobe from the result block
	input qspi_pkg::byte_t rd_data,
	output qspi_pkg::insn_t insn,
	output logic insn_valid,
	output logic wr_valid,
	output qspi_pkg::byte_t wr_data,
	output logic rd_ready,             // asks the result block for the next byte
	output qspi_pkg::nibble_t dq_out,
	output logic dq_oe
);

	qspi_pkg::xcvr_state_t state;
	logic insn_cnt;                   // which instruction nibble comes next
	qspi_pkg::nibble_t dq_hi;         // high nibble of a write byte
	qspi_pkg::byte_t rd_data_next;    // next byte to shift out
	qspi_pkg::byte_t rd_data_fwd;     // same, with rd_data forwarded

	////////////////////////////////////////
	// read byte holding

	always_comb begin
		rd_data_fwd = rd_data_next;
		if (rd_valid)
			rd_data_fwd = rd_data;  // fresh byte wins over the held one
	end

	// first byte is requested with the instruction, the rest while the
	// low nibble of the current byte goes out
	assign rd_ready = insn_valid | ((state == qspi_pkg::st_rd_lo) & sck_rise);

	////////////////////////////////////////
	// control FSM

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= qspi_pkg::st_deselected;
			insn_cnt <= 1'b0;
			insn_valid <= 1'b0;
			wr_valid <= 1'b0;
			dq_oe <= 1'b0;  // bus released out of reset
		end else begin
			insn_valid <= 1'b0;
			wr_valid <= 1'b0;

			if (sck_rise) begin
				case (state)
					qspi_pkg::st_insn: begin
						insn_cnt <= ~insn_cnt;
						if (insn_cnt) begin  // second nibble just arrived
							insn_valid <= 1'b1;
							state <= qspi_pkg::st_turnaround;
						end
					end
					qspi_pkg::st_turnaround: begin
						if (rd_mode) begin
							dq_oe <= 1'b1;  // take the bus
							state <= qspi_pkg::st_rd_lo;  // high nibble goes out now
						end else begin
							state <= qspi_pkg::st_wr_hi;
						end
					end
					qspi_pkg::st_wr_hi: state <= qspi_pkg::st_wr_lo;
					qspi_pkg::st_wr_lo: begin
						wr_valid <= 1'b1;  // byte complete
						state <= qspi_pkg::st_wr_hi;
					end
					qspi_pkg::st_rd_hi: state <= qspi_pkg::st_rd_lo;
					qspi_pkg::st_rd_lo: state <= qspi_pkg::st_rd_hi;
					default: ;  // deselected, ignore sck
				endcase
			end

			// deselect aborts whatever was in flight
			if (cs_n_s) begin
				state <= qspi_pkg::st_deselected;
				dq_oe <= 1'b0;
			end

			if (start) begin
				state <= qspi_pkg::st_insn;
				insn_cnt <= 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// data path

	always_ff @(posedge clk) begin
		rd_data_next <= rd_data_fwd;
		if (sck_rise) begin
			case (state)
				qspi_pkg::st_insn: insn <= {insn[3:0], dq_s};       // msn first
				qspi_pkg::st_turnaround: dq_out <= rd_data_fwd[7:4];  // only seen when oe rises
				qspi_pkg::st_wr_hi: dq_hi <= dq_s;
				qspi_pkg::st_wr_lo: wr_data <= {dq_hi, dq_s};
				qspi_pkg::st_rd_hi: dq_out <= rd_data_fwd[7:4];
				qspi_pkg::st_rd_lo: dq_out <= rd_data_fwd[3:0];
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// checks

	// bus may only stay driven for the one clk that reacts to deselect
	a_oe_deselect: assert property (@(posedge clk) disable iff (!rst_n)
		(dq_oe && cs_n_s) |-> $rose(cs_n_s));

	// a command is either a write or a read, never both at once
	a_wr_rd_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(wr_valid && rd_ready));

endmodule

// ==== design/qspi_cmd_decode.sv ====
`timescale 1ns/1ps

module qspi_cmd_decode (
	input logic clk,
	input logic rst_n,
	input qspi_pkg::insn_t insn,        // held by the transceiver until next start
	input logic insn_valid,
	output logic rd_mode,               // direction for the turnaround
	output qspi_pkg::qspi_cmd_t cmd,
	output logic cmd_valid
);

	logic rsvd_clear;               // reserved field is all zero
	qspi_pkg::reg_addr_t insn_addr; // start register field

	////////////////////////////////////////
	// field split

	assign rsvd_clear = ~|insn[qspi_pkg::INSN_RSVD_MSB:qspi_pkg::INSN_RSVD_LSB];
	assign insn_addr = insn[qspi_pkg::INSN_ADDR_MSB:0];

	// a read with reserved bits set still turns the bus around
	// the result block returns zeros for it
	assign rd_mode = insn[qspi_pkg::INSN_READ_BIT];

	////////////////////////////////////////
	// command register

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cmd <= '0;
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= insn_valid;  // one clk behind the instruction
			if (insn_valid) begin
				cmd.is_read <= insn[qspi_pkg::INSN_READ_BIT];
				cmd.legal <= rsvd_clear;
				cmd.addr <= insn_addr;
			end
		end
	end

	// the command lands one clk after the strobe
	// and the transceiver must still hold the same instruction by then
	a_cmd_lag: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_valid |-> (cmd.is_read == rd_mode) && (cmd.legal == rsvd_clear) &&
			(cmd.addr == insn_addr));

endmodule

// ==== design/qspi_reg_execute.sv ====
`timescale 1ns/1ps

module qspi_reg_execute #(
	parameter int REG_COUNT = 8
) (
	input logic clk,
	input logic rst_n,
	input logic cs_n_s,                 // deselect drops a partial word
	input qspi_pkg::qspi_cmd_t cmd,
	input logic cmd_valid,
	input logic wr_valid,
	input qspi_pkg::byte_t wr_data,
	input qspi_pkg::reg_addr_t rd_addr,
	output qspi_pkg::word_t rd_word     // combinational read port
);

	localparam int PTR_W = (REG_COUNT > 1) ? $clog2(REG_COUNT) : 1;
	localparam int CNT_W = $clog2(qspi_pkg::BYTES_PER_WORD + 1);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(REG_COUNT - 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(qspi_pkg::BYTES_PER_WORD - 1);

	qspi_pkg::word_t bank [REG_COUNT];  // the registers
	logic [PTR_W-1:0] wr_ptr;           // register the next full word lands in
	logic [CNT_W-1:0] byte_cnt;         // bytes already in the accumulator
	logic wr_en;                        // current command is a legal write
	logic commit;                       // accumulator holds a full word
	qspi_pkg::word_t acc;               // word being assembled, msb first

	////////////////////////////////////////
	// control and bank

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_COUNT; i++)
				bank[i] <= '0;
			wr_ptr <= '0;
			byte_cnt <= '0;
			wr_en <= 1'b0;
			commit <= 1'b0;
		end else begin
			commit <= 1'b0;
			if (commit) begin
				bank[wr_ptr] <= acc;
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;  // wrap to first reg
			end

			if (cmd_valid) begin
				wr_ptr <= cmd.addr[PTR_W-1:0];
				wr_en <= cmd.legal & ~cmd.is_read;
				byte_cnt <= '0;
			end else if (cs_n_s) begin
				byte_cnt <= '0;  // partial word is thrown away
			end else if (wr_valid && wr_en) begin
				if (byte_cnt == CNT_LAST) begin
					byte_cnt <= '0;
					commit <= 1'b1;  // written next clk
				end else begin
					byte_cnt <= byte_cnt + 1'b1;
				end
			end
		end
	end

	// shifts every byte, only counted bytes ever get committed
	always_ff @(posedge clk) begin
		if (wr_valid)
			acc <= {acc[23:0], wr_data};
	end

	assign rd_word = bank[rd_addr[PTR_W-1:0]];

	a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
		byte_cnt < qspi_pkg::BYTES_PER_WORD);

endmodule

// ==== design/qspi_read_return.sv ====
`timescale 1ns/1ps

module qspi_read_return #(
	parameter int REG_COUNT = 8
) (
	input logic clk,
	input logic rst_n,
	input qspi_pkg::qspi_cmd_t cmd,
	input logic cmd_valid,
	input logic rd_ready,
	input qspi_pkg::word_t rd_word,
	output qspi_pkg::reg_addr_t rd_addr,
	output logic rd_valid,
	output qspi_pkg::byte_t rd_data
);

	localparam int PTR_W = (REG_COUNT > 1) ? $clog2(REG_COUNT) : 1;
	localparam int IDX_W = $clog2(qspi_pkg::BYTES_PER_WORD);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(REG_COUNT - 1);
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(qspi_pkg::BYTES_PER_WORD - 1);

	logic [PTR_W-1:0] rd_ptr;    // register being sent
	logic [IDX_W-1:0] byte_idx;  // 0 is the msb
	logic rd_en;                 // legal read in progress
	logic [PTR_W-1:0] cur_ptr;
	logic [IDX_W-1:0] cur_idx;
	logic cur_en;

	// first byte is answered in the same clk the command lands, so bypass it
	assign cur_ptr = cmd_valid ? cmd.addr[PTR_W-1:0] : rd_ptr;
	assign cur_idx = cmd_valid ? '0 : byte_idx;
	assign cur_en = cmd_valid ? (cmd.legal & cmd.is_read) : rd_en;

	assign rd_addr = qspi_pkg::reg_addr_t'(cur_ptr);
	assign rd_data = cur_en ? rd_word[8 * (IDX_LAST - cur_idx) +: 8] : '0;  // zeros if illegal

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			byte_idx <= '0;
			rd_en <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_ready;  // answer exactly one clk later
			if (cmd_valid) begin
				rd_ptr <= cur_ptr;
				byte_idx <= '0;
				rd_en <= cur_en;
			end
			if (rd_valid) begin  // byte taken, step to the next one
				if (cur_idx == IDX_LAST) begin
					byte_idx <= '0;
					rd_ptr <= (cur_ptr == PTR_LAST) ? '0 : cur_ptr + 1'b1;
				end else begin
					byte_idx <= cur_idx + 1'b1;
					rd_ptr <= cur_ptr;
				end
			end
		end
	end

endmodule

// ==== design/qspi_regs_top.sv ====
`timescale 1ns/1ps

module qspi_regs_top #(
	parameter int REG_COUNT = 8  // power of two, 8 at most
) (
	input logic clk,
	input logic rst_n,
	input logic sck,
	input logic cs_n,
	input qspi_pkg::nibble_t dq_in,
	output qspi_pkg::nibble_t dq_out,
	output logic dq_oe
);

	////////////////////////////////////////
	// internal links

	logic cs_n_s;
	qspi_pkg::nibble_t dq_s;
	logic sck_rise;
	logic start;
	qspi_pkg::insn_t insn;
	logic insn_valid;
	logic rd_mode;
	qspi_pkg::qspi_cmd_t cmd;
	logic cmd_valid;
	logic wr_valid;
	qspi_pkg::byte_t wr_data;
	logic rd_ready;
	logic rd_valid;
	qspi_pkg::byte_t rd_data;
	qspi_pkg::reg_addr_t rd_addr;
	qspi_pkg::word_t rd_word;

	////////////////////////////////////////
	// pins to transceiver

	qspi_input_sync u_sync (
		.clk(clk), .rst_n(rst_n), .sck(sck), .cs_n(cs_n), .dq_in(dq_in),
		.cs_n_s(cs_n_s), .dq_s(dq_s), .sck_rise(sck_rise), .start(start)
	);

	qspi_device_if u_xcvr (
		.clk(clk), .rst_n(rst_n), .cs_n_s(cs_n_s), .dq_s(dq_s),
		.sck_rise(sck_rise), .start(start), .rd_mode(rd_mode),
		.rd_valid(rd_valid), .rd_data(rd_data), .insn(insn),
		.insn_valid(insn_valid), .wr_valid(wr_valid), .wr_data(wr_data),
		.rd_ready(rd_ready), .dq_out(dq_out), .dq_oe(dq_oe)
	);

	////////////////////////////////////////
	// command and registers

	qspi_cmd_decode u_decode (
		.clk(clk), .rst_n(rst_n), .insn(insn), .insn_valid(insn_valid),
		.rd_mode(rd_mode), .cmd(cmd), .cmd_valid(cmd_valid)
	);

	qspi_reg_execute #(.REG_COUNT(REG_COUNT)) u_exec (
		.clk(clk), .rst_n(rst_n), .cs_n_s(cs_n_s), .cmd(cmd),
		.cmd_valid(cmd_valid), .wr_valid(wr_valid), .wr_data(wr_data),
		.rd_addr(rd_addr), .rd_word(rd_word)
	);

	qspi_read_return #(.REG_COUNT(REG_COUNT)) u_result (
		.clk(clk), .rst_n(rst_n), .cmd(cmd), .cmd_valid(cmd_valid),
		.rd_ready(rd_ready), .rd_word(rd_word), .rd_addr(rd_addr),
		.rd_valid(rd_valid), .rd_data(rd_data)
	);

endmodule

// ==== bench/tb_qspi_regs.sv ====
`timescale 1ns/1ps

module tb_qspi_regs;

	localparam int REG_COUNT = 8;
	localparam int N_TXN = 10;
	localparam int SCK_HALF = 4;  // clk per sck half period, 80 ns sck
	localparam int OE_LIMIT = 4;  // clk allowed for dq_oe to follow cs# or turnaround
	localparam int IDLE_CLK = 8;  // gap between transactions

	// expected-data modes
	localparam logic [1:0] EXP_MODEL = 2'd0;  // data follows the register model
	localparam logic [1:0] EXP_ZERO = 2'd1;   // reserved bits set, no write, zero reads
	localparam logic [1:0] EXP_CUT = 2'd2;    // cs# rises after two bytes of the last word

	typedef struct packed {
		logic is_read;          // host reads from the device
		qspi_pkg::insn_t insn;  // instruction byte as sent
		logic [3:0] words;      // burst length in words
		logic [1:0] mode;       // expected-data mode
	} txn_t;

	logic clk;
	logic rst_n;
	logic sck;
	logic cs_n;
	qspi_pkg::nibble_t dq_in;
	qspi_pkg::nibble_t dq_out;
	logic dq_oe;

	txn_t txn_table [N_TXN];
	qspi_pkg::word_t model [REG_COUNT];  // reference copy of the bank
	logic [31:0] rng_state;              // xorshift state
	int value_errors;
	int timeouts;

	qspi_regs_top #(.REG_COUNT(REG_COUNT)) dut (
		.clk(clk), .rst_n(rst_n), .sck(sck), .cs_n(cs_n), .dq_in(dq_in),
		.dq_out(dq_out), .dq_oe(dq_oe)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;  // 100 MHz
	end

	////////////////////////////////////////
	// host helpers

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// inputs change just after the clk edge
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	// one sck period: data set while low, device samples on the rise,
	// host samples dq_out on its own fall
	task automatic sck_pulse(input qspi_pkg::nibble_t d, output qspi_pkg::nibble_t q,
			output logic oe);
		dq_in = d;
		repeat (SCK_HALF) tick();
		sck = 1'b1;
		repeat (SCK_HALF) tick();
		sck = 1'b0;
		q = dq_out;   // value driven on the previous rise
		oe = dq_oe;
	endtask

	task automatic idle_check(input int n);
		repeat (n) begin
			tick();
			assert (!dq_oe) else begin
				value_errors++;
				$display("FAILED @%0t: dq_oe high while deselected", $time);
			end
		end
	endtask

	task automatic start_txn(input qspi_pkg::insn_t insn);
		qspi_pkg::nibble_t q;
		logic oe;
		cs_n = 1'b0;
		sck_pulse(insn[7:4], q, oe);  // high nibble first
		sck_pulse(insn[3:0], q, oe);
		sck_pulse(4'h0, q, oe);       // turnaround
	endtask

	task automatic wait_bus_driven();
		int waited;
		waited = 0;
		while (!dq_oe && waited < OE_LIMIT) begin
			tick();
			waited++;
		end
		assert (dq_oe) else begin
			timeouts++;
			$display("dq_oe did not rise within %0d clk of the turnaround", OE_LIMIT);
		end
	endtask

	task automatic end_txn(input logic was_read);
		int waited;
		repeat (SCK_HALF) tick();  // let the last byte land
		cs_n = 1'b1;
		dq_in = '0;
		if (was_read) begin
			waited = 0;
			while (dq_oe && waited < OE_LIMIT) begin
				tick();
				waited++;
			end
			assert (!dq_oe) else begin
				timeouts++;
				$display("dq_oe still high %0d clk after cs_n went high", OE_LIMIT);
			end
		end
		idle_check(IDLE_CLK);
	endtask

	task automatic write_byte(input qspi_pkg::byte_t b);
		qspi_pkg::nibble_t q;
		logic oe;
		sck_pulse(b[7:4], q, oe);
		sck_pulse(b[3:0], q, oe);
	endtask

	task automatic read_byte(input qspi_pkg::byte_t exp);
		qspi_pkg::nibble_t hi;
		qspi_pkg::nibble_t lo;
		logic oe_hi;
		logic oe_lo;
		sck_pulse(4'h0, hi, oe_hi);
		sck_pulse(4'h0, lo, oe_lo);
		assert (oe_hi && oe_lo) else begin
			value_errors++;
			$display("FAILED @%0t: dq_oe low during read data", $time);
		end
		assert ({hi, lo} == exp) else begin
			value_errors++;
			$display("FAILED @%0t: read byte %02h, expected %02h", $time, {hi, lo}, exp);
		end
	endtask

	////////////////////////////////////////
	// main sequence

	initial begin
		txn_t cur;
		int addr;
		int nbytes;
		qspi_pkg::word_t word;
		qspi_pkg::byte_t exp;
		rst_n = 1'b0;
		sck = 1'b0;
		cs_n = 1'b1;
		dq_in = '0;
		value_errors = 0;
		timeouts = 0;
		rng_state = 32'd5;
		for (int i = 0; i < REG_COUNT; i++)
			model[i] = '0;  // bank resets to zero

		txn_table = '{
			'{1'b1, 8'h80, 4'd8, EXP_MODEL},  // whole bank reads zero after reset
			'{1'b0, 8'h05, 4'd1, EXP_MODEL},  // one word into register 5
			'{1'b1, 8'h85, 4'd1, EXP_MODEL},
			'{1'b0, 8'h06, 4'd3, EXP_MODEL},  // 6, 7, then wrap to 0
			'{1'b1, 8'h86, 4'd3, EXP_MODEL},
			'{1'b0, 8'h45, 4'd2, EXP_ZERO},   // bit 6 set, write ignored
			'{1'b1, 8'hc6, 4'd2, EXP_ZERO},   // reserved read, zeros on the bus
			'{1'b1, 8'h85, 4'd2, EXP_MODEL},  // 5 and 6 untouched
			'{1'b0, 8'h07, 4'd1, EXP_CUT},    // cs# up after two bytes
			'{1'b1, 8'h80, 4'd8, EXP_MODEL}   // register 7 still holds its old word
		};

		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		idle_check(IDLE_CLK);

		for (int t = 0; t < N_TXN; t++) begin
			cur = txn_table[t];
			addr = int'(cur.insn[2:0]);
			start_txn(cur.insn);
			if (cur.is_read) begin
				wait_bus_driven();
				for (int w = 0; w < int'(cur.words); w++) begin
					for (int b = 0; b < qspi_pkg::BYTES_PER_WORD; b++) begin
						exp = (cur.mode == EXP_ZERO) ? 8'h00 : model[addr][8 * (3 - b) +: 8];
						read_byte(exp);  // msb first
					end
					addr = (addr == REG_COUNT - 1) ? 0 : addr + 1;
				end
			end else begin
				for (int w = 0; w < int'(cur.words); w++) begin
					rng_state = xorshift32(rng_state);
					word = rng_state;
					nbytes = (cur.mode == EXP_CUT && w == int'(cur.words) - 1) ? 2 :
						qspi_pkg::BYTES_PER_WORD;
					for (int b = 0; b < nbytes; b++)
						write_byte(word[8 * (3 - b) +: 8]);
					// only a full word of a legal write reaches the bank
					if (cur.mode != EXP_ZERO && nbytes == qspi_pkg::BYTES_PER_WORD)
						model[addr] = word;
					addr = (addr == REG_COUNT - 1) ? 0 : addr + 1;
				end
			end
			end_txn(cur.is_read);
		end

		$display("errors: %0d wrong values, %0d timeouts", value_errors, timeouts);
		if (value_errors == 0 && timeouts == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== files.f ====
design/qspi_pkg.sv
design/qspi_input_sync.sv
design/qspi_device_if.sv
design/qspi_cmd_decode.sv
design/qspi_reg_execute.sv
design/qspi_read_return.sv
design/qspi_regs_top.sv
bench/tb_qspi_regs.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the register port testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f files.f --top-module tb_qspi_regs -o tb_qspi_regs
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_qspi_regs)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
	exit 0
fi
exit 1
